// File: vlog.f
+incdir+.
mips_reg_pkg.sv
mips_fpr_pkg.sv
write_steer.sv
reg_storage.sv
read_select.sv
regfile_top.sv
tb_regfile.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing
TOP       = tb_regfile
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_regfile_checks.svh
// register file testbench compare tasks and shadow model
// expected outputs follow the write and read rules one table row at a time
`ifndef TB_REGFILE_CHECKS_SVH
`define TB_REGFILE_CHECKS_SVH

int    error_count = 0;
int    cur_test = 0;
int    test_errors [0:6];

word_t int_sh [NUM_REGS];
word_t fpr_sh [NUM_REGS]; // one word per FPR index, even holds the msw
hilo_t hilo_sh;
word_t out_rs_d;
word_t out_rs_m;
word_t out_rt_d;
word_t out_rt_m;

function automatic void model_reset();
	for (int k = 0; k < NUM_REGS; k++) begin
		int_sh[k] = '0;
		fpr_sh[k] = '0;
	end
	for (int k = 0; k <= 6; k++) test_errors[k] = 0;
	hilo_sh  = '0;
	out_rs_d = '0;
	out_rs_m = '0;
	out_rt_d = '0;
	out_rt_m = '0;
endfunction

function automatic row_t model_row(input row_t r);
	logic [63:0] wide;
	reg_idx_t    dest;
	word_t       val;
	wide = r.wr_data64;
	// reads see the contents before this row's write
	if (r.fp_read) begin
		if (!r.rs[0]) begin
			out_rs_m = fpr_sh[r.rs];
			out_rs_d = fpr_sh[{r.rs[4:1], 1'b1}];
		end
		if (!r.rt[0]) begin
			out_rt_m = fpr_sh[r.rt];
			out_rt_d = fpr_sh[{r.rt[4:1], 1'b1}];
		end
	end else begin
		out_rs_d = int_sh[r.rs];
		out_rt_d = r.store_byte ? {24'h0, int_sh[r.rt][7:0]} : int_sh[r.rt];
	end
	if (r.reg_write) begin
		if (r.wide_write && r.muldiv) begin
			hilo_sh.hi = wide[63:32];
			hilo_sh.lo = wide[31:0];
		end else if (r.fp_write) begin
			if (!r.wr_addr[0]) begin
				fpr_sh[r.wr_addr] = r.wide_write ? wide[63:32] : 32'h0;
				fpr_sh[{r.wr_addr[4:1], 1'b1}] = r.wide_write ? wide[31:0] : r.wr_data;
			end
		end else begin
			dest = r.wr_addr;
			val  = r.wr_data;
			if (r.load_byte) val = {24'h0, r.wr_data[7:0]};
			else if (r.jal) dest = 5'd31;
			if (dest != 5'd0) int_sh[dest] = val;
		end
	end
	r.exp_rs_data = out_rs_d;
	r.exp_rs_msw  = out_rs_m;
	r.exp_rt_data = out_rt_d;
	r.exp_rt_msw  = out_rt_m;
	r.exp_hilo    = hilo_sh;
	return r;
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
	if (got !== exp) begin
		$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		error_count++;
		test_errors[cur_test]++;
	end
endtask

task automatic check_pair(input string name, input fpr_pair_t got, input fpr_pair_t exp);
	if (got !== exp) begin
		$display("ERR %0t %s got %h_%h expected %h_%h", $time, name,
			got.msw, got.lsw, exp.msw, exp.lsw);
		error_count++;
		test_errors[cur_test]++;
	end
endtask

task automatic check_hilo(input string name, input hilo_t got, input hilo_t exp);
	if (got !== exp) begin
		$display("ERR %0t %s got %h_%h expected %h_%h", $time, name,
			got.hi, got.lo, exp.hi, exp.lo);
		error_count++;
		test_errors[cur_test]++;
	end
endtask

task automatic check_row(input row_t r);
	fpr_pair_t got_rs;
	fpr_pair_t got_rt;
	fpr_pair_t exp_rs;
	fpr_pair_t exp_rt;
	hilo_t     got_hl;
	cur_test   = int'(r.test);
	got_rs     = {rs_msw, rs_data};
	got_rt     = {rt_msw, rt_data};
	exp_rs     = {r.exp_rs_msw, r.exp_rs_data};
	exp_rt     = {r.exp_rt_msw, r.exp_rt_data};
	got_hl     = {hi, lo};
	if (r.chk_rd) begin
		if (r.fp_read) begin
			check_pair("rs_msw_o/rs_data_o", got_rs, exp_rs);
			check_pair("rt_msw_o/rt_data_o", got_rt, exp_rt);
		end else begin
			check_word("rs_data_o", rs_data, r.exp_rs_data);
			check_word("rt_data_o", rt_data, r.exp_rt_data);
			check_word("rs_msw_o", rs_msw, r.exp_rs_msw); // held through integer reads
			check_word("rt_msw_o", rt_msw, r.exp_rt_msw);
		end
	end
	if (r.chk_hl) check_hilo("hi_o/lo_o", got_hl, r.exp_hilo);
endtask

`endif

// File: tb_regfile.sv
// testbench for the MIPS register file
// applies a table of writes and reads, compares outputs with a shadow model
`default_nettype none

module tb_regfile
	import mips_reg_pkg::*, mips_fpr_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int          RESET_CYCLES = 4;
	localparam int          HALF_PERIOD  = 20; // 40 ns clock
	localparam int          DRIVE_DELAY  = 2;  // inputs change after the edge
	localparam int          SLACK        = 20;
	localparam logic [31:0] LFSR_SEED    = 32'h5154_91eb;
	localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

	// one table row is one clock cycle
	typedef struct packed {
		logic [3:0] test;
		logic       reg_write;
		logic       load_byte;
		logic       jal;
		logic       fp_write;
		logic       muldiv;
		logic       wide_write;
		logic       fp_read;
		logic       store_byte;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   wr_addr;
		word_t      wr_data;
		wide_word_u wr_data64;
		word_t      exp_rs_data;
		word_t      exp_rs_msw;
		word_t      exp_rt_data;
		word_t      exp_rt_msw;
		hilo_t      exp_hilo;
		logic       chk_rd; // compare operand outputs
		logic       chk_hl; // compare hi_o/lo_o
	} row_t;

	logic       Clk;
	logic       rst_i;
	reg_idx_t   rs_addr;
	reg_idx_t   rt_addr;
	logic       fp_read;
	logic       store_byte;
	logic       reg_write;
	logic       load_byte;
	logic       jal;
	logic       fp_write;
	logic       muldiv;
	logic       wide_write;
	reg_idx_t   wr_addr;
	word_t      wr_data;
	wide_word_u wr_data64;
	word_t      rs_data;
	word_t      rs_msw;
	word_t      rt_data;
	word_t      rt_msw;
	word_t      hi;
	word_t      lo;

	row_t        rows [$];
	logic [31:0] lfsr_state;
	int          cycle_limit = 0;
	int          cycles = 0;
	int          tests_run = 0;
	int          tests_bad = 0;
	string       test_name [1:6];

	`include "tb_regfile_checks.svh"

	regfile_top UUT (
		.Clk          (Clk),
		.rst_i        (rst_i),
		.rs_addr_i    (rs_addr),
		.rt_addr_i    (rt_addr),
		.fp_read_i    (fp_read),
		.store_byte_i (store_byte),
		.reg_write_i  (reg_write),
		.load_byte_i  (load_byte),
		.jal_i        (jal),
		.fp_write_i   (fp_write),
		.muldiv_i     (muldiv),
		.wide_write_i (wide_write),
		.wr_addr_i    (wr_addr),
		.wr_data_i    (wr_data),
		.wr_data64_i  (wr_data64),
		.rs_data_o    (rs_data),
		.rs_msw_o     (rs_msw),
		.rt_data_o    (rt_data),
		.rt_msw_o     (rt_msw),
		.hi_o         (hi),
		.lo_o         (lo)
	);

	initial begin
		Clk = 1'b0;
		forever #HALF_PERIOD Clk = ~Clk;
	end

	// galois form shifting right
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	function automatic word_t rand_word();
		word_t w;
		w = '0;
		for (int k = 0; k < 32; k++) begin
			w = {w[30:0], lfsr_state[0]}; // one step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
		return w;
	endfunction

	function automatic wide_word_u rand_wide();
		word_t upper;
		word_t lower;
		upper = rand_word();
		lower = rand_word();
		return wide_word_u'({upper, lower});
	endfunction

	function automatic row_t blank_row(input int test);
		row_t r;
		r = '0;
		r.test = 4'(test);
		return r;
	endfunction

	function automatic row_t read_row(input int test, input int rs, input int rt,
		input logic fp);
		row_t r;
		r = blank_row(test);
		r.rs      = reg_idx_t'(rs);
		r.rt      = reg_idx_t'(rt);
		r.fp_read = fp;
		r.chk_rd  = 1'b1;
		r.chk_hl  = 1'b1;
		return r;
	endfunction

	// plain integer write that callers extend with other controls
	function automatic row_t write_row(input int test, input int addr);
		row_t r;
		r = blank_row(test);
		r.reg_write = 1'b1;
		r.wr_addr   = reg_idx_t'(addr);
		r.wr_data   = rand_word();
		r.wr_data64 = rand_wide();
		r.chk_hl    = 1'b1;
		return r;
	endfunction

	function automatic void push_row(input row_t r);
		rows.push_back(model_row(r)); // expected values filled here
	endfunction

	task automatic build_rows();
		row_t r;
		for (int i = 0; i < NUM_REGS; i++) push_row(read_row(1, i, 31 - i, 1'b0));
		for (int i = 0; i < NUM_REGS; i += 2) push_row(read_row(1, i, 30 - i, 1'b1));
		for (int i = 1; i < NUM_REGS; i += 3) push_row(write_row(2, i));
		for (int i = 1; i < NUM_REGS; i += 3) push_row(read_row(2, i, i, 1'b0));
		push_row(write_row(2, 0));
		push_row(read_row(2, 0, 0, 1'b0));
		r = write_row(2, 7);
		r.jal = 1'b1; // lands in $ra
		push_row(r);
		push_row(read_row(2, 31, 7, 1'b0));
		r = write_row(2, 12);
		r.load_byte = 1'b1;
		push_row(r);
		push_row(read_row(2, 12, 12, 1'b0));
		r = read_row(3, 4, 4, 1'b0);
		r.store_byte = 1'b1;
		push_row(r);
		r = read_row(3, 13, 31, 1'b0);
		r.store_byte = 1'b1;
		push_row(r);
		r = write_row(4, 6);
		r.fp_write   = 1'b1;
		r.wide_write = 1'b1;
		push_row(r);
		push_row(read_row(4, 6, 7, 1'b1)); // odd rt holds its outputs
		r = write_row(4, 10);
		r.fp_write   = 1'b1;
		r.wide_write = 1'b1; // nonzero msw for the next write to clear
		push_row(r);
		r = write_row(4, 10);
		r.fp_write = 1'b1;
		push_row(r);
		push_row(read_row(4, 10, 6, 1'b1));
		r = write_row(4, 11);
		r.fp_write   = 1'b1;
		r.wide_write = 1'b1;
		push_row(r);
		push_row(read_row(4, 10, 10, 1'b1));
		push_row(read_row(4, 3, 6, 1'b1));
		push_row(read_row(4, 6, 9, 1'b1));
		r = write_row(5, 4);
		r.muldiv     = 1'b1;
		r.wide_write = 1'b1;
		push_row(r);
		r = write_row(5, 6);
		r.muldiv     = 1'b1;
		r.wide_write = 1'b1;
		r.fp_write   = 1'b1; // HI/LO still wins
		push_row(r);
		push_row(read_row(5, 4, 4, 1'b0));
		push_row(read_row(5, 6, 10, 1'b1));
		r = write_row(6, 19);
		r.rs     = 5'd19;
		r.rt     = 5'd19;
		r.chk_rd = 1'b1;
		push_row(r);
		push_row(read_row(6, 19, 19, 1'b0));
		r = write_row(6, 6);
		r.fp_write   = 1'b1;
		r.wide_write = 1'b1;
		r.fp_read    = 1'b1;
		r.rs         = 5'd6;
		r.rt         = 5'd6;
		r.chk_rd     = 1'b1;
		push_row(r);
		push_row(read_row(6, 6, 6, 1'b1));
	endtask

	task automatic drive_row(input row_t r);
		rs_addr    = r.rs;
		rt_addr    = r.rt;
		fp_read    = r.fp_read;
		store_byte = r.store_byte;
		reg_write  = r.reg_write;
		load_byte  = r.load_byte;
		jal        = r.jal;
		fp_write   = r.fp_write;
		muldiv     = r.muldiv;
		wide_write = r.wide_write;
		wr_addr    = r.wr_addr;
		wr_data    = r.wr_data;
		wr_data64  = r.wr_data64;
	endtask

	task automatic report_test(input int t);
		tests_run++;
		if (test_errors[t] == 0) begin
			$display("test %0d %s: ok", t, test_name[t]);
		end else begin
			tests_bad++;
			$display("test %0d %s: %0d errors", t, test_name[t], test_errors[t]);
		end
	endtask

	// watchdog
	initial begin
		wait (cycle_limit != 0);
		while (cycles < cycle_limit) begin
			@(posedge Clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the table did not finish", cycles);
		$display("tests failed");
		$finish;
	end

	initial begin
		int i;
		$timeformat(-9, 1, " ns", 0);
		rst_i = 1'b1;
		drive_row(blank_row(0));
		test_name[1] = "reset state";
		test_name[2] = "integer write/read";
		test_name[3] = "store byte";
		test_name[4] = "fp pairs";
		test_name[5] = "hi/lo write";
		test_name[6] = "read during write";
		lfsr_state = LFSR_SEED;
		model_reset();
		build_rows();
		cycle_limit = rows.size() + RESET_CYCLES + SLACK;
		repeat (RESET_CYCLES) @(posedge Clk);
		#DRIVE_DELAY;
		rst_i = 1'b0;
		for (i = 0; i < rows.size(); i++) begin
			drive_row(rows[i]);
			@(posedge Clk);
			#DRIVE_DELAY;
			check_row(rows[i]); // outputs of the row sampled at this edge
			if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
				report_test(int'(rows[i].test));
			end
		end
		drive_row(blank_row(0));
		$display("%0d tests run, %0d failed, %0d errors",
			tests_run, tests_bad, error_count);
		if (error_count == 0 && tests_bad == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: regfile_top.sv
// MIPS register file top level
// write steering into storage, registered operand reads on the rising edge
`default_nettype none

module regfile_top
	import mips_reg_pkg::*, mips_fpr_pkg::*;
(
	input  wire logic       Clk,
	input  wire logic       rst_i,

	// read side
	input  wire reg_idx_t   rs_addr_i,
	input  wire reg_idx_t   rt_addr_i,
	input  wire logic       fp_read_i,
	input  wire logic       store_byte_i,

	// write side
	input  wire logic       reg_write_i,
	input  wire logic       load_byte_i,
	input  wire logic       jal_i,
	input  wire logic       fp_write_i,
	input  wire logic       muldiv_i,
	input  wire logic       wide_write_i,
	input  wire reg_idx_t   wr_addr_i,
	input  wire word_t      wr_data_i,
	input  wire wide_word_u wr_data64_i,

	output word_t           rs_data_o,
	output word_t           rs_msw_o,
	output word_t           rt_data_o,
	output word_t           rt_msw_o,
	output word_t           hi_o,
	output word_t           lo_o
);

	logic      int_we;
	reg_idx_t  int_addr;
	word_t     int_data;
	logic      fpr_we;
	pair_idx_t fpr_pair_addr;
	fpr_pair_t fpr_pair_data;
	logic      hilo_we;
	hilo_t     hilo_data;

	// storage read taps
	word_t     int_rs;
	word_t     int_rt;
	fpr_pair_t fpr_rs;
	fpr_pair_t fpr_rt;

	write_steer u_write_steer (
		.reg_write_i     (reg_write_i),
		.load_byte_i     (load_byte_i),
		.jal_i           (jal_i),
		.fp_write_i      (fp_write_i),
		.muldiv_i        (muldiv_i),
		.wide_write_i    (wide_write_i),
		.wr_addr_i       (wr_addr_i),
		.wr_data_i       (wr_data_i),
		.wr_data64_i     (wr_data64_i),
		.int_we_o        (int_we),
		.int_addr_o      (int_addr),
		.int_data_o      (int_data),
		.fpr_we_o        (fpr_we),
		.fpr_pair_addr_o (fpr_pair_addr),
		.fpr_pair_data_o (fpr_pair_data),
		.hilo_we_o       (hilo_we),
		.hilo_data_o     (hilo_data)
	);

	reg_storage u_reg_storage (
		.Clk             (Clk),
		.rst_i           (rst_i),
		.int_we_i        (int_we),
		.int_addr_i      (int_addr),
		.int_data_i      (int_data),
		.fpr_we_i        (fpr_we),
		.fpr_pair_addr_i (fpr_pair_addr),
		.fpr_pair_data_i (fpr_pair_data),
		.hilo_we_i       (hilo_we),
		.hilo_data_i     (hilo_data),
		.rs_addr_i       (rs_addr_i),
		.rt_addr_i       (rt_addr_i),
		.int_rs_o        (int_rs),
		.int_rt_o        (int_rt),
		.fpr_rs_o        (fpr_rs),
		.fpr_rt_o        (fpr_rt),
		.hi_o            (hi_o),
		.lo_o            (lo_o)
	);

	read_select u_read_select (
		.Clk          (Clk),
		.rst_i        (rst_i),
		.rs_addr_i    (rs_addr_i),
		.rt_addr_i    (rt_addr_i),
		.fp_read_i    (fp_read_i),
		.store_byte_i (store_byte_i),
		.int_rs_i     (int_rs),
		.int_rt_i     (int_rt),
		.fpr_rs_i     (fpr_rs),
		.fpr_rt_i     (fpr_rt),
		.rs_data_o    (rs_data_o),
		.rs_msw_o     (rs_msw_o),
		.rt_data_o    (rt_data_o),
		.rt_msw_o     (rt_msw_o)
	);

endmodule

`default_nettype wire

// File: read_select.sv
// operand read port formatting
// registers rs/rt outputs with store byte and FPR pair selection
`default_nettype none

module read_select
	import mips_reg_pkg::*, mips_fpr_pkg::*;
(
	input  wire logic      Clk,
	input  wire logic      rst_i,

	input  wire reg_idx_t  rs_addr_i,
	input  wire reg_idx_t  rt_addr_i,
	input  wire logic      fp_read_i,
	input  wire logic      store_byte_i,

	input  wire word_t     int_rs_i,
	input  wire word_t     int_rt_i,
	input  wire fpr_pair_t fpr_rs_i,
	input  wire fpr_pair_t fpr_rt_i,

	output word_t          rs_data_o,
	output word_t          rs_msw_o,
	output word_t          rt_data_o,
	output word_t          rt_msw_o
);

	byte_t st_byte;   // low byte of rt for store byte
	word_t rt_word;   // integer rt after store byte select

	assign st_byte = int_rt_i[BYTE_W-1:0];
	assign rt_word = store_byte_i ? word_t'(st_byte) : int_rt_i;

	always_ff @(posedge Clk) begin
		if (rst_i) begin
			rs_data_o <= '0;
			rs_msw_o  <= '0;
			rt_data_o <= '0;
			rt_msw_o  <= '0;
		end else if (fp_read_i) begin
			// only even indices name a pair, odd ones hold
			if (!rs_addr_i[0]) begin
				rs_data_o <= fpr_rs_i.lsw;
				rs_msw_o  <= fpr_rs_i.msw;
			end
			if (!rt_addr_i[0]) begin
				rt_data_o <= fpr_rt_i.lsw;
				rt_msw_o  <= fpr_rt_i.msw;
			end
		end else begin
			rs_data_o <= int_rs_i; // msw outputs keep their value
			rt_data_o <= rt_word;
		end
	end

endmodule

`default_nettype wire

// File: reg_storage.sv
// register storage
// integer bank, FPR pair bank and HI/LO with combinational read taps
`default_nettype none

module reg_storage
	import mips_reg_pkg::*, mips_fpr_pkg::*;
(
	input  wire logic      Clk,
	input  wire logic      rst_i,

	input  wire logic      int_we_i,
	input  wire reg_idx_t  int_addr_i,
	input  wire word_t     int_data_i,

	input  wire logic      fpr_we_i,
	input  wire pair_idx_t fpr_pair_addr_i,
	input  wire fpr_pair_t fpr_pair_data_i,

	input  wire logic      hilo_we_i,
	input  wire hilo_t     hilo_data_i,

	input  wire reg_idx_t  rs_addr_i,
	input  wire reg_idx_t  rt_addr_i,

	output word_t          int_rs_o,
	output word_t          int_rt_o,
	output fpr_pair_t      fpr_rs_o,
	output fpr_pair_t      fpr_rt_o,
	output word_t          hi_o,
	output word_t          lo_o
);

	word_t     int_regs [NUM_REGS];
	fpr_pair_t fpr_regs [NUM_PAIRS];
	hilo_t     hilo_q;

	pair_idx_t rs_pair;
	pair_idx_t rt_pair;

	// drop the low bit to get the pair
	assign rs_pair = rs_addr_i[IDX_W-1:1];
	assign rt_pair = rt_addr_i[IDX_W-1:1];

	always_ff @(posedge Clk) begin
		if (rst_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				int_regs[i] <= '0;
			end
			for (int i = 0; i < NUM_PAIRS; i++) begin
				fpr_regs[i] <= '0;
			end
			hilo_q <= '0;
		end else begin
			// steering guarantees at most one of these per cycle
			if (int_we_i) begin
				int_regs[int_addr_i] <= int_data_i;
			end
			if (fpr_we_i) begin
				fpr_regs[fpr_pair_addr_i] <= fpr_pair_data_i;
			end
			if (hilo_we_i) begin
				hilo_q <= hilo_data_i;
			end
		end
	end

	// read taps, sampled by read_select
	assign int_rs_o = int_regs[rs_addr_i];
	assign int_rt_o = int_regs[rt_addr_i];
	assign fpr_rs_o = fpr_regs[rs_pair];
	assign fpr_rt_o = fpr_regs[rt_pair];

	assign hi_o = hilo_q.hi; // straight from the register
	assign lo_o = hilo_q.lo;

endmodule

`default_nettype wire

// File: write_steer.sv
// register file write steering
// decodes the write controls into at most one write on the integer, FPR or HI/LO bank
`default_nettype none

module write_steer
	import mips_reg_pkg::*, mips_fpr_pkg::*;
(
	input  wire logic       reg_write_i,
	input  wire logic       load_byte_i,
	input  wire logic       jal_i,
	input  wire logic       fp_write_i,
	input  wire logic       muldiv_i,
	input  wire logic       wide_write_i,
	input  wire reg_idx_t   wr_addr_i,
	input  wire word_t      wr_data_i,
	input  wire wide_word_u wr_data64_i,

	output logic            int_we_o,
	output reg_idx_t        int_addr_o,
	output word_t           int_data_o,

	output logic            fpr_we_o,
	output pair_idx_t       fpr_pair_addr_o,
	output fpr_pair_t       fpr_pair_data_o,

	output logic            hilo_we_o,
	output hilo_t           hilo_data_o
);

	byte_t ld_byte;    // low byte of the write word
	logic  hilo_sel;   // wide muldiv write wins over everything
	logic  fpr_sel;
	logic  int_sel;

	assign ld_byte = wr_data_i[BYTE_W-1:0];

	// priority: HI/LO, then FPR pair, then integer
	assign hilo_sel = reg_write_i && wide_write_i && muldiv_i;
	assign fpr_sel  = reg_write_i && !hilo_sel && fp_write_i;
	assign int_sel  = reg_write_i && !hilo_sel && !fp_write_i;

	// HI/LO view of the wide word
	assign hilo_we_o   = hilo_sel;
	assign hilo_data_o = wr_data64_i.hilo;

	// FPR pair, odd destinations are ignored
	assign fpr_we_o        = fpr_sel && !wr_addr_i[0];
	assign fpr_pair_addr_o = wr_addr_i[IDX_W-1:1];

	always_comb begin
		if (wide_write_i) begin
			fpr_pair_data_o = wr_data64_i.pair; // msw to even, lsw to odd
		end else begin
			// single precision lands in the odd register, even one cleared
			fpr_pair_data_o.msw = '0;
			fpr_pair_data_o.lsw = wr_data_i;
		end
	end

	// integer destination and payload
	always_comb begin
		int_addr_o = wr_addr_i;
		int_data_o = wr_data_i;
		if (load_byte_i) begin
			int_data_o = word_t'(ld_byte); // zero extended
		end else if (jal_i) begin
			int_addr_o = REG_RA; // return address, wr_addr_i ignored
		end
	end

	// $zero never takes a write
	assign int_we_o = int_sel && (int_addr_o != REG_ZERO);

endmodule

`default_nettype wire

// File: mips_fpr_pkg.sv
// floating-point pair and HI/LO definitions
// a 64-bit write word decodes either as an even/odd FPR pair or as HI/LO
`default_nettype none

package mips_fpr_pkg;

	import mips_reg_pkg::*;

	// pair number is the FPR index without its low bit
	localparam int PAIR_IDX_W = IDX_W - 1;
	localparam int NUM_PAIRS  = 1 << PAIR_IDX_W;

	typedef logic [PAIR_IDX_W-1:0] pair_idx_t;

	// big endian pair, msw lives in the even register
	typedef struct packed {
		word_t msw; // even register
		word_t lsw; // odd register
	} fpr_pair_t;

	// multiply/divide result
	typedef struct packed {
		word_t hi;
		word_t lo;
	} hilo_t;

	// the wide write port carries either layout
	typedef union packed {
		fpr_pair_t pair;
		hilo_t     hilo;
	} wide_word_u;

endpackage

`default_nettype wire

// File: mips_reg_pkg.sv
// integer register file definitions
// word, byte and index types plus the named registers of the MIPS integer bank
`default_nettype none

package mips_reg_pkg;

	// instruction set widths
	localparam int WORD_W = 32;
	localparam int BYTE_W = 8;
	localparam int IDX_W  = 5;

	// integer bank depth
	localparam int NUM_REGS = 1 << IDX_W;

	// one data word as seen by the core
	typedef logic [WORD_W-1:0] word_t;

	// load/store byte payload
	typedef logic [BYTE_W-1:0] byte_t;

	// rs, rt and destination index
	typedef logic [IDX_W-1:0] reg_idx_t;

	// $zero is hardwired, writes to it are dropped
	localparam reg_idx_t REG_ZERO = 5'd0;

	// $ra, target of jal
	localparam reg_idx_t REG_RA = 5'd31;

endpackage

`default_nettype wire
